// ==== rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

////////////////////////////////////////////////////////////
// Core widths and reset vector
////////////////////////////////////////////////////////////

`define XLEN     64     // Data and address width.
`define INST_W   32     // Instruction word width.
`define RESET_PC 64'h0  // First fetch address.

`endif

// ==== rv_pkg.sv ====
package rv_pkg;

	////////////////////////////////////////////////////////////
	// Instruction formats
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One fetched word, read through whichever view the opcode calls for.
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	////////////////////////////////////////////////////////////
	// Control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		alu_zero, alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, alu_pass_b
	} alu_op_e;

	typedef enum logic {op1_rs1, op1_pc} op1_src_e;

	typedef enum logic [1:0] {op2_rs2, op2_imm, op2_four} op2_src_e;

	typedef enum logic [1:0] {
		stall_next = 2'b00,  // Load the decoded bundle.
		stall_zero = 2'b10   // Load a bubble.
	} stall_e;

endpackage

// ==== ex_ctrl_if.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

interface ex_ctrl_if import rv_pkg::*; ();

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] imm;
	op1_src_e         op1_src;
	op2_src_e         op2_src;
	alu_op_e          alu_op;
	logic             rd_wena;
	logic [4:0]       rd_waddr;
	logic             branch;
	logic             jump;
	logic [2:0]       funct3;  // Branch condition.

	modport drive (
		output pc, rs1_data, rs2_data, imm, op1_src, op2_src, alu_op,
		output rd_wena, rd_waddr, branch, jump, funct3
	);

	modport take (
		input pc, rs1_data, rs2_data, imm, op1_src, op2_src, alu_op,
		input rd_wena, rd_waddr, branch, jump, funct3
	);

endinterface

// ==== fetch_unit.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module fetch_unit import rv_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic [`XLEN-1:0]   wb_adr,
	input  logic [`INST_W-1:0] wb_dat_i,
	input  logic               wb_ack,
	input  logic               redirect,
	input  logic [`XLEN-1:0]   redirect_pc,
	input  logic               consume,
	output logic               if_valid,
	output logic [`XLEN-1:0]   if_pc,
	output inst_u              if_inst
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	logic [`XLEN-1:0] next_pc;
	logic [`XLEN-1:0] issue_pc;
	logic             discard;
	logic             ack_seen;
	logic             issue;

	assign wb_stb   = wb_cyc;
	assign ack_seen = wb_cyc && wb_ack;
	assign issue    = !wb_cyc || ack_seen;                  // Bus idle or request done.
	assign issue_pc = redirect ? redirect_pc : next_pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_cyc  <= 1'b0;
			next_pc <= `RESET_PC;
			discard <= 1'b0;
		end else if (issue) begin
			wb_cyc  <= 1'b1;
			next_pc <= issue_pc + PC_STEP;
			discard <= 1'b0;
		end else if (redirect) begin
			next_pc <= redirect_pc;                          // Wait for the stale ack.
			discard <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			wb_adr <= issue_pc;
		end
	end

	////////////////////////////////////////////////////////////
	// One-entry fetched-instruction buffer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			if_valid <= 1'b0;
		end else if (ack_seen && !discard && !redirect) begin
			if_valid <= 1'b1;
		end else if (consume || redirect) begin
			if_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ack_seen) begin
			if_pc   <= wb_adr;
			if_inst <= wb_dat_i;
		end
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module reg_file (
	input  logic             clk,
	input  logic             rst,
	input  logic [4:0]       rs1_addr,
	input  logic [4:0]       rs2_addr,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data,
	input  logic             wena,
	input  logic [4:0]       waddr,
	input  logic [`XLEN-1:0] wdata
);

	logic [`XLEN-1:0] regs [1:31];  // x0 has no storage.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wena && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// A read of the register being written sees the new value.
	function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end else if (wena && waddr == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1_addr);
		rs2_data = read_port(rs2_addr);
	end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module decoder import rv_pkg::*; (
	input  logic             if_valid,
	input  logic [`XLEN-1:0] if_pc,
	input  inst_u            if_inst,
	input  logic             redirect,
	output logic [4:0]       rs1_addr,
	output logic [4:0]       rs2_addr,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	output logic             consume,
	output stall_e           stall,
	ex_ctrl_if.drive         id_bus
);

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [6:0]       opcode;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic             is_op;
	logic             alt;
	alu_op_e          arith_op;

	assign opcode   = if_inst.r_fmt.opcode;
	assign rs1_addr = if_inst.r_fmt.rs1;
	assign rs2_addr = if_inst.r_fmt.rs2;

	assign consume  = if_valid && !redirect;  // Wrong-path word is dropped.
	assign stall    = consume ? stall_next : stall_zero;

	assign imm_i = {{(`XLEN-12){if_inst.i_fmt.imm12[11]}}, if_inst.i_fmt.imm12};
	assign imm_b = {{(`XLEN-13){if_inst.b_fmt.imm12}}, if_inst.b_fmt.imm12,
		if_inst.b_fmt.imm11, if_inst.b_fmt.imm10_5, if_inst.b_fmt.imm4_1, 1'b0};
	assign imm_u = {{(`XLEN-32){if_inst.u_fmt.imm20[19]}}, if_inst.u_fmt.imm20, 12'h000};
	assign imm_j = {{(`XLEN-21){if_inst.j_fmt.imm20}}, if_inst.j_fmt.imm20,
		if_inst.j_fmt.imm19_12, if_inst.j_fmt.imm11, if_inst.j_fmt.imm10_1, 1'b0};

	// Register and immediate forms share funct3; only OP has SUB.
	assign is_op = (opcode == OPC_OP);
	assign alt   = if_inst.r_fmt.funct7[5];  // Bit 30 in both forms.

	always_comb begin
		case (if_inst.r_fmt.funct3)
			3'b000:  arith_op = (is_op && alt) ? alu_sub : alu_add;
			3'b001:  arith_op = alu_sll;
			3'b010:  arith_op = alu_slt;
			3'b011:  arith_op = alu_sltu;
			3'b100:  arith_op = alu_xor;
			3'b101:  arith_op = alt ? alu_sra : alu_srl;
			3'b110:  arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	always_comb begin
		id_bus.pc       = if_pc;
		id_bus.rs1_data = rs1_data;
		id_bus.rs2_data = rs2_data;
		id_bus.rd_waddr = if_inst.r_fmt.rd;
		id_bus.funct3   = if_inst.r_fmt.funct3;
		id_bus.imm      = '0;
		id_bus.op1_src  = op1_rs1;
		id_bus.op2_src  = op2_rs2;
		id_bus.alu_op   = alu_zero;
		id_bus.rd_wena  = 1'b0;
		id_bus.branch   = 1'b0;
		id_bus.jump     = 1'b0;
		case (opcode)
			OPC_OP: begin
				id_bus.alu_op  = arith_op;
				id_bus.rd_wena = 1'b1;
			end
			OPC_OP_IMM: begin
				id_bus.imm     = imm_i;
				id_bus.op2_src = op2_imm;
				id_bus.alu_op  = arith_op;
				id_bus.rd_wena = 1'b1;
			end
			OPC_LUI: begin
				id_bus.imm     = imm_u;
				id_bus.op2_src = op2_imm;
				id_bus.alu_op  = alu_pass_b;
				id_bus.rd_wena = 1'b1;
			end
			OPC_AUIPC: begin
				id_bus.imm     = imm_u;
				id_bus.op1_src = op1_pc;
				id_bus.op2_src = op2_imm;
				id_bus.alu_op  = alu_add;
				id_bus.rd_wena = 1'b1;
			end
			OPC_JAL: begin
				id_bus.imm     = imm_j;
				id_bus.op1_src = op1_pc;
				id_bus.op2_src = op2_four;  // Link value.
				id_bus.alu_op  = alu_add;
				id_bus.rd_wena = 1'b1;
				id_bus.jump    = 1'b1;
			end
			OPC_BRANCH: begin
				id_bus.imm    = imm_b;
				id_bus.branch = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== id_ex.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module id_ex import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  stall_e   stall,
	ex_ctrl_if.take  id_bus,
	ex_ctrl_if.drive ex_bus
);

	logic load;

	assign load = !rst && (stall == stall_next);  // Anything else makes a bubble.

	always_ff @(posedge clk) begin
		if (load) begin
			ex_bus.pc       <= id_bus.pc;
			ex_bus.rs1_data <= id_bus.rs1_data;
			ex_bus.rs2_data <= id_bus.rs2_data;
			ex_bus.imm      <= id_bus.imm;
			ex_bus.op1_src  <= id_bus.op1_src;
			ex_bus.op2_src  <= id_bus.op2_src;
			ex_bus.alu_op   <= id_bus.alu_op;
			ex_bus.rd_wena  <= id_bus.rd_wena;
			ex_bus.rd_waddr <= id_bus.rd_waddr;
			ex_bus.branch   <= id_bus.branch;
			ex_bus.jump     <= id_bus.jump;
			ex_bus.funct3   <= id_bus.funct3;
		end else begin
			ex_bus.pc       <= '0;
			ex_bus.rs1_data <= '0;
			ex_bus.rs2_data <= '0;
			ex_bus.imm      <= '0;
			ex_bus.op1_src  <= op1_rs1;
			ex_bus.op2_src  <= op2_rs2;
			ex_bus.alu_op   <= alu_zero;
			ex_bus.rd_wena  <= 1'b0;
			ex_bus.rd_waddr <= 5'd0;
			ex_bus.branch   <= 1'b0;
			ex_bus.jump     <= 1'b0;
			ex_bus.funct3   <= 3'b000;
		end
	end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module ex_stage import rv_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	ex_ctrl_if.take          ex_bus,
	output logic             wena,
	output logic [4:0]       waddr,
	output logic [`XLEN-1:0] wdata,
	output logic             redirect,
	output logic [`XLEN-1:0] redirect_pc,
	output logic             retire_valid,
	output logic [`XLEN-1:0] retire_pc,
	output logic [4:0]       retire_rd,
	output logic [`XLEN-1:0] retire_data
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic [`XLEN-1:0] alu_res;
	logic             taken;
	logic             bubble;
	logic             writes_rd;

	assign op1 = (ex_bus.op1_src == op1_pc) ? ex_bus.pc : ex_bus.rs1_data;

	always_comb begin
		case (ex_bus.op2_src)
			op2_rs2:  op2 = ex_bus.rs2_data;
			op2_imm:  op2 = ex_bus.imm;
			op2_four: op2 = PC_STEP;
			default:  op2 = '0;
		endcase
	end

	always_comb begin
		case (ex_bus.alu_op)
			alu_add:    alu_res = op1 + op2;
			alu_sub:    alu_res = op1 - op2;
			alu_and:    alu_res = op1 & op2;
			alu_or:     alu_res = op1 | op2;
			alu_xor:    alu_res = op1 ^ op2;
			alu_sll:    alu_res = op1 << op2[5:0];
			alu_srl:    alu_res = op1 >> op2[5:0];
			alu_sra:    alu_res = $signed(op1) >>> op2[5:0];
			alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
			alu_sltu:   alu_res = {{(`XLEN-1){1'b0}}, op1 < op2};
			alu_pass_b: alu_res = op2;
			default:    alu_res = '0;
		endcase
	end

	// Branch condition from funct3.
	always_comb begin
		case (ex_bus.funct3)
			3'b000:  taken = (ex_bus.rs1_data == ex_bus.rs2_data);
			3'b001:  taken = (ex_bus.rs1_data != ex_bus.rs2_data);
			3'b100:  taken = $signed(ex_bus.rs1_data) < $signed(ex_bus.rs2_data);
			3'b101:  taken = $signed(ex_bus.rs1_data) >= $signed(ex_bus.rs2_data);
			default: taken = 1'b0;
		endcase
	end

	assign redirect    = ex_bus.jump || (ex_bus.branch && taken);
	assign redirect_pc = ex_bus.pc + ex_bus.imm;

	assign wena  = ex_bus.rd_wena;
	assign waddr = ex_bus.rd_waddr;
	assign wdata = alu_res;

	////////////////////////////////////////////////////////////
	// Retire report
	////////////////////////////////////////////////////////////

	assign bubble    = (ex_bus.pc == '0) && !ex_bus.rd_wena && !ex_bus.branch && !ex_bus.jump;
	assign writes_rd = ex_bus.rd_wena && (ex_bus.rd_waddr != 5'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= !bubble;
		end
	end

	always_ff @(posedge clk) begin
		retire_pc   <= ex_bus.pc;
		retire_rd   <= writes_rd ? ex_bus.rd_waddr : 5'd0;
		retire_data <= writes_rd ? alu_res : '0;
	end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic [`XLEN-1:0]   wb_adr,
	input  logic [`INST_W-1:0] wb_dat_i,
	input  logic               wb_ack,
	output logic               retire_valid,
	output logic [`XLEN-1:0]   retire_pc,
	output logic [4:0]         retire_rd,
	output logic [`XLEN-1:0]   retire_data
);

	logic             if_valid;
	logic [`XLEN-1:0] if_pc;
	inst_u            if_inst;
	logic             consume;
	stall_e           stall;
	logic             redirect;
	logic [`XLEN-1:0] redirect_pc;
	logic [4:0]       rs1_addr;
	logic [4:0]       rs2_addr;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic             rf_wena;
	logic [4:0]       rf_waddr;
	logic [`XLEN-1:0] rf_wdata;

	ex_ctrl_if id_bus ();
	ex_ctrl_if ex_bus ();

	fetch_unit u_fetch (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack,
		.redirect, .redirect_pc, .consume, .if_valid, .if_pc, .if_inst
	);

	reg_file u_regs (
		.clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.wena(rf_wena), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	decoder u_dec (
		.if_valid, .if_pc, .if_inst, .redirect, .rs1_addr, .rs2_addr,
		.rs1_data, .rs2_data, .consume, .stall, .id_bus(id_bus.drive)
	);

	id_ex u_id_ex (
		.clk, .rst, .stall, .id_bus(id_bus.take), .ex_bus(ex_bus.drive)
	);

	ex_stage u_ex (
		.clk, .rst, .ex_bus(ex_bus.take),
		.wena(rf_wena), .waddr(rf_waddr), .wdata(rf_wdata),
		.redirect, .redirect_pc, .retire_valid, .retire_pc, .retire_rd, .retire_data
	);

endmodule

// ==== tb_rv_prog.svh ====
`ifndef TB_RV_PROG_SVH
`define TB_RV_PROG_SVH

////////////////////////////////////////////////////////////
// Program image and expected retire order
////////////////////////////////////////////////////////////

// Each call places one word at the next address. Arguments are the word, rd, data.
task automatic load_program();
	retires(i_type(F3_ADD, 5'd1, 5'd0, 12'h005), 5'd1, 64'h5);
	retires(i_type(F3_ADD, 5'd2, 5'd0, 12'hffd), 5'd2, 64'hffff_ffff_ffff_fffd);
	retires(r_type(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 5'd3, 64'h2);
	retires(r_type(F7_ALT, F3_ADD, 5'd4, 5'd0, 5'd1), 5'd4, 64'hffff_ffff_ffff_fffb);
	retires(r_type(F7_BASE, F3_XOR, 5'd5, 5'd1, 5'd2), 5'd5, 64'hffff_ffff_ffff_fff8);
	retires(r_type(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2), 5'd6, 64'hffff_ffff_ffff_fffd);
	retires(r_type(F7_BASE, F3_AND, 5'd7, 5'd4, 5'd2), 5'd7, 64'hffff_ffff_ffff_fff9);
	retires(i_type(F3_SLL, 5'd8, 5'd1, 12'h03e), 5'd8, 64'h4000_0000_0000_0000);
	retires(i_type(F3_SR, 5'd9, 5'd2, 12'h401), 5'd9, 64'hffff_ffff_ffff_fffe);  // srai by 1.
	retires(i_type(F3_SR, 5'd10, 5'd2, 12'h03c), 5'd10, 64'hf);
	// Register shifts use only the low six bits of 65.
	retires(i_type(F3_ADD, 5'd11, 5'd0, 12'h041), 5'd11, 64'h41);
	retires(r_type(F7_BASE, F3_SLL, 5'd12, 5'd1, 5'd11), 5'd12, 64'ha);
	retires(r_type(F7_ALT, F3_SR, 5'd13, 5'd4, 5'd11), 5'd13, 64'hffff_ffff_ffff_fffd);
	retires(r_type(F7_BASE, F3_SLT, 5'd14, 5'd2, 5'd1), 5'd14, 64'h1);
	retires(r_type(F7_BASE, F3_SLTU, 5'd15, 5'd2, 5'd1), 5'd15, 64'h0);
	retires(i_type(F3_SLTU, 5'd16, 5'd1, 12'hfff), 5'd16, 64'h1);
	retires(i_type(F3_XOR, 5'd17, 5'd1, 12'h7ff), 5'd17, 64'h7fa);
	retires(i_type(F3_OR, 5'd18, 5'd0, 12'h800), 5'd18, 64'hffff_ffff_ffff_f800);
	retires(i_type(F3_AND, 5'd19, 5'd2, 12'h0f0), 5'd19, 64'hf0);
	// Back-to-back dependent chain.
	retires(i_type(F3_ADD, 5'd20, 5'd0, 12'h001), 5'd20, 64'h1);
	retires(r_type(F7_BASE, F3_ADD, 5'd20, 5'd20, 5'd20), 5'd20, 64'h2);
	retires(r_type(F7_BASE, F3_ADD, 5'd20, 5'd20, 5'd20), 5'd20, 64'h4);
	retires(r_type(F7_ALT, F3_ADD, 5'd21, 5'd20, 5'd1), 5'd21, 64'hffff_ffff_ffff_ffff);
	// Upper immediates.
	retires(u_type(OPC_LUI, 5'd22, 20'h80000), 5'd22, 64'hffff_ffff_8000_0000);
	retires(u_type(OPC_LUI, 5'd23, 20'h12345), 5'd23, 64'h1234_5000);
	retires(u_type(OPC_AUIPC, 5'd24, 20'h00001), 5'd24, 64'h1064);
	retires(u_type(OPC_AUIPC, 5'd25, 20'hfffff), 5'd25, 64'hffff_ffff_ffff_f068);
	////////////////////////////////////////////////////////////
	// Taken branches skip the next word
	////////////////////////////////////////////////////////////
	retires(b_type(F3_BEQ, 5'd1, 5'd1, 13'h008), 5'd0, 64'h0);
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h063));
	retires(b_type(F3_BNE, 5'd1, 5'd2, 13'h008), 5'd0, 64'h0);
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h062));
	retires(b_type(F3_BLT, 5'd2, 5'd1, 13'h008), 5'd0, 64'h0);
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h061));
	retires(b_type(F3_BEQ, 5'd1, 5'd2, 13'h008), 5'd0, 64'h0);  // Falls through.
	retires(b_type(F3_BNE, 5'd1, 5'd1, 13'h008), 5'd0, 64'h0);
	retires(b_type(F3_BGE, 5'd2, 5'd1, 13'h008), 5'd0, 64'h0);
	retires(b_type(F3_BGE, 5'd1, 5'd2, 13'h008), 5'd0, 64'h0);
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h060));
	retires(r_type(F7_BASE, F3_ADD, 5'd26, 5'd26, 5'd1), 5'd26, 64'h5);  // x26 still zero.
	// Jumps and x0.
	retires(j_type(5'd27, 21'h0000c), 5'd27, 64'ha0);
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h001));
	skipped(i_type(F3_ADD, 5'd26, 5'd0, 12'h002));
	retires(r_type(F7_BASE, F3_ADD, 5'd28, 5'd27, 5'd26), 5'd28, 64'ha5);
	retires(i_type(F3_ADD, 5'd0, 5'd0, 12'h07b), 5'd0, 64'h0);
	retires(r_type(F7_BASE, F3_ADD, 5'd29, 5'd0, 5'd1), 5'd29, 64'h5);
	retires(j_type(5'd0, 21'h00008), 5'd0, 64'h0);
	skipped(i_type(F3_ADD, 5'd30, 5'd0, 12'h032));
	retires(i_type(F3_ADD, 5'd30, 5'd30, 12'h001), 5'd30, 64'h1);
endtask

`endif

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module tb_rv_core import rv_pkg::*; ();

	localparam logic [6:0]  OPC_OP     = 7'b0110011;
	localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0]  OPC_LUI    = 7'b0110111;
	localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0]  OPC_JAL    = 7'b1101111;
	localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
	localparam logic [6:0]  F7_BASE    = 7'h00;
	localparam logic [6:0]  F7_ALT     = 7'h20;
	localparam logic [2:0]  F3_ADD     = 3'b000;
	localparam logic [2:0]  F3_SLL     = 3'b001;
	localparam logic [2:0]  F3_SLT     = 3'b010;
	localparam logic [2:0]  F3_SLTU    = 3'b011;
	localparam logic [2:0]  F3_XOR     = 3'b100;
	localparam logic [2:0]  F3_SR      = 3'b101;
	localparam logic [2:0]  F3_OR      = 3'b110;
	localparam logic [2:0]  F3_AND     = 3'b111;
	localparam logic [2:0]  F3_BEQ     = 3'b000;
	localparam logic [2:0]  F3_BNE     = 3'b001;
	localparam logic [2:0]  F3_BLT     = 3'b100;
	localparam logic [2:0]  F3_BGE     = 3'b101;
	localparam logic [31:0] NOP        = 32'h0000_0013;  // addi x0, x0, 0.
	localparam int          ROW_CYCLES = 20;             // Watchdog budget per row.

	logic               clk;
	logic               rst;
	logic               wb_cyc;
	logic               wb_stb;
	logic [`XLEN-1:0]   wb_adr;
	logic [`INST_W-1:0] wb_dat_i;
	logic               wb_ack;
	logic               retire_valid;
	logic [`XLEN-1:0]   retire_pc;
	logic [4:0]         retire_rd;
	logic [`XLEN-1:0]   retire_data;

	logic [31:0]      prog_q [$];
	logic [`XLEN-1:0] exp_pc [$];
	logic [4:0]       exp_rd [$];
	logic [`XLEN-1:0] exp_data [$];
	int               errors;
	int               rows_failed;
	int               cur_row;
	bit               tables_ready;
	int               wait_left;
	bit               busy;
	logic [`XLEN-1:0] req_adr;

	rv_core dut (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack,
		.retire_valid, .retire_pc, .retire_rd, .retire_data
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		inst_u w;
		w.r_fmt.funct7 = funct7;
		w.r_fmt.rs2    = rs2;
		w.r_fmt.rs1    = rs1;
		w.r_fmt.funct3 = funct3;
		w.r_fmt.rd     = rd;
		w.r_fmt.opcode = OPC_OP;
		return w;
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] funct3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		inst_u w;
		w.i_fmt.imm12  = imm;
		w.i_fmt.rs1    = rs1;
		w.i_fmt.funct3 = funct3;
		w.i_fmt.rd     = rd;
		w.i_fmt.opcode = OPC_OP_IMM;
		return w;
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opcode, input logic [4:0] rd,
			input logic [19:0] imm);
		inst_u w;
		w.u_fmt.imm20  = imm;
		w.u_fmt.rd     = rd;
		w.u_fmt.opcode = opcode;
		return w;
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] funct3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		inst_u w;
		w.b_fmt.imm12   = off[12];
		w.b_fmt.imm10_5 = off[10:5];
		w.b_fmt.rs2     = rs2;
		w.b_fmt.rs1     = rs1;
		w.b_fmt.funct3  = funct3;
		w.b_fmt.imm4_1  = off[4:1];
		w.b_fmt.imm11   = off[11];
		w.b_fmt.opcode  = OPC_BRANCH;
		return w;
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
		inst_u w;
		w.j_fmt.imm20    = off[20];
		w.j_fmt.imm10_1  = off[10:1];
		w.j_fmt.imm11    = off[11];
		w.j_fmt.imm19_12 = off[19:12];
		w.j_fmt.rd       = rd;
		w.j_fmt.opcode   = OPC_JAL;
		return w;
	endfunction

	// Word that retires, with its pc taken from its place in the image.
	task automatic retires(input logic [31:0] word, input logic [4:0] rd,
			input logic [`XLEN-1:0] data);
		logic [`XLEN-1:0] pc;
		pc = prog_q.size();
		exp_pc.push_back(pc << 2);
		exp_rd.push_back(rd);
		exp_data.push_back(data);
		prog_q.push_back(word);
	endtask

	task automatic skipped(input logic [31:0] word);
		prog_q.push_back(word);
	endtask

	`include "tb_rv_prog.svh"

	function automatic logic [31:0] fetch_word(input logic [`XLEN-1:0] adr);
		if ((adr >> 2) < prog_q.size()) begin
			return prog_q[adr >> 2];
		end
		return NOP;
	endfunction

	task automatic compare(input string what, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] want);
		if (got !== want) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone memory with random ack wait
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(52843));
		forever begin
			@(negedge clk);
			wb_ack = 1'b0;
			if (!rst && wb_cyc) begin
				compare("wb_stb", wb_stb, 1'b1);
			end
			if (!rst && wb_cyc && wb_stb) begin
				if (!busy) begin
					busy      = 1'b1;
					req_adr   = wb_adr;
					wait_left = $urandom_range(3, 0);
				end
				compare("wb_adr", wb_adr, req_adr);  // Held until the ack.
				if (wait_left == 0) begin
					wb_ack   = 1'b1;
					wb_dat_i = fetch_word(wb_adr);
					busy     = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		int errors_before;
		clk          = 1'b0;
		rst          = 1'b1;
		wb_ack       = 1'b0;
		wb_dat_i     = '0;
		errors       = 0;
		rows_failed  = 0;
		cur_row      = 0;
		busy         = 1'b0;
		load_program();
		tables_ready = 1'b1;
		repeat (4) @(negedge clk);
		compare("wb_cyc", wb_cyc, 1'b0);
		compare("wb_stb", wb_stb, 1'b0);
		compare("retire_valid", retire_valid, 1'b0);
		rst = 1'b0;
		for (int i = 0; i < exp_pc.size(); i++) begin
			cur_row       = i;
			errors_before = errors;
			@(negedge clk);
			while (!retire_valid) begin
				@(negedge clk);
			end
			compare("retire_pc", retire_pc, exp_pc[i]);
			compare("retire_rd", retire_rd, exp_rd[i]);
			compare("retire_data", retire_data, exp_data[i]);
			if (errors == errors_before) begin
				$display("Row %0d pc %h ok", i, exp_pc[i]);
			end else begin
				rows_failed++;
				$display("Row %0d pc %h mismatch", i, exp_pc[i]);
			end
		end
		$display("Rows checked %0d, passed %0d, failed %0d, errors %0d", exp_pc.size(),
			exp_pc.size() - rows_failed, rows_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		wait (tables_ready);
		repeat (exp_pc.size() * ROW_CYCLES) @(posedge clk);
		$display("Timeout, row %0d with pc %h never retired", cur_row, exp_pc[cur_row]);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== rv_core.f ====
+incdir+.
rv_pkg.sv
ex_ctrl_if.sv
fetch_unit.sv
reg_file.sv
decoder.sv
id_ex.sv
ex_stage.sv
rv_core.sv
tb_rv_core.sv
